// ==== common/cpu_pkg.sv ====
package cpu_pkg;

    localparam int XLEN = 64;
    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // Machine CSRs
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    localparam logic [XLEN-1:0] CAUSE_ECALL_M = 64'd11;

    // mstatus bit positions
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} a_sel_e;
    typedef enum logic [1:0] {B_RS2, B_IMM, B_FOUR} b_sel_e;

    typedef struct packed {
        alu_op_e    alu_op;
        a_sel_e     a_sel;
        b_sel_e     b_sel;
        logic       reg_wr;
        logic       mem_rd;
        logic       mem_wr;
        logic [2:0] mem_op;
        logic       br;
        logic [2:0] br_op;
        logic       jump;
        logic       jalr;
        logic       csr;
        logic       csr_imm;
        logic [1:0] csr_op;
        logic       ecall;
        logic       mret;
        logic       ebreak;
    } ctrl_t;

    typedef struct packed {
        logic            rd;
        logic            wr;
        logic [2:0]      op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

endpackage

// ==== compile.f ====
common/cpu_pkg.sv
rtl/pc_unit.sv
rtl/instr_decode.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/csr_file.sv
rtl/cpu_core.sv
dv/cpu_core_assert.sv
dv/tb_cpu_core.sv

// ==== dv/cpu_core_assert.sv ====
`timescale 1ns/1ps

module cpu_core_assert (
    input logic                     clk,
    input logic                     rst,
    input logic [cpu_pkg::XLEN-1:0] pc,
    input cpu_pkg::mem_req_t        mem,
    input logic                     error
);
    import cpu_pkg::*;

    assert property (@(posedge clk) !(mem.rd && mem.wr))
        else $error("memory read and write strobes both high");

    assert property (@(posedge clk) !rst |=> pc == RESET_PC)
        else $error("pc not at reset vector after reset");

    assert property (@(posedge clk) disable iff (!rst) error |-> !mem.wr)
        else $error("store issued while error is high");

    assert property (@(posedge clk) disable iff (!rst) error |=> $stable(pc))
        else $error("pc moved while error is high");

    assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

endmodule

bind cpu_core cpu_core_assert i_cpu_core_assert (
    .clk(clk), .rst(rst), .pc(pc), .mem(mem), .error(error)
);

// ==== dv/tb_cpu_core.sv ====
`timescale 1ns/1ps

module tb_cpu_core;
    import cpu_pkg::*;

    localparam logic [31:0] EBREAK = 32'h0010_0073;
    localparam logic [31:0] ECALL  = 32'h0000_0073;
    localparam logic [31:0] MRET   = 32'h3020_0073;

    logic            clk;
    logic            rst;
    logic [31:0]     instr;
    logic [XLEN-1:0] data_rd;
    logic [XLEN-1:0] pc;
    mem_req_t        mem;
    logic            error;
    logic            done;

    logic [31:0]     imem [0:127];
    logic [7:0]      dmem [logic [63:0]];
    logic [63:0]     st_data [$];
    logic [2:0]      st_op [$];
    logic [2:0]      ld_op [$];
    logic [63:0]     trace [$];
    logic [63:0]     imem_idx;
    logic [31:0]     seed;
    int              pi;
    int              errors;
    int              tests;

    cpu_core i_cpu_core (
        .clk(clk), .rst(rst), .instr(instr), .data_rd(data_rd),
        .pc(pc), .mem(mem), .error(error), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Outside the program window the instruction memory reads as zero
    assign imem_idx = (pc - RESET_PC) >> 2;
    assign instr    = (imem_idx < 128) ? imem[imem_idx[6:0]] : 32'h0;

    function automatic logic [7:0] fill_byte(input logic [63:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ a[39:32] ^ a[47:40]
            ^ a[55:48] ^ a[63:56] ^ 8'ha5;
    endfunction

    function automatic logic [7:0] rd_byte(input logic [63:0] a);
        return dmem.exists(a) ? dmem[a] : fill_byte(a);
    endfunction

    function automatic logic [63:0] load_data(input logic [63:0] a, input logic [2:0] op);
        logic [63:0] raw;
        raw = '0;
        for (int i = 0; i < 8; i++)
            if (i < (1 << op[1:0]))
                raw[8*i +: 8] = rd_byte(a + i);
        case (op)
            3'd0:    return {{56{raw[7]}}, raw[7:0]};
            3'd1:    return {{48{raw[15]}}, raw[15:0]};
            3'd2:    return {{32{raw[31]}}, raw[31:0]};
            default: return raw;
        endcase
    endfunction

    assign data_rd = mem.rd ? load_data(mem.addr, mem.op) : '0;

    always @(posedge clk) begin
        if (mem.wr) begin
            st_data.push_back(mem.wdata);
            st_op.push_back(mem.op);
            for (int i = 0; i < (1 << mem.op[1:0]); i++)
                dmem[mem.addr + i] = mem.wdata[8*i +: 8];
        end
        if (mem.rd)
            ld_op.push_back(mem.op);
        if (rst && !done && !error)
            trace.push_back(pc);
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_csr(input logic [11:0] csr, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd);
        return {csr, rs1, f3, rd, OPC_SYSTEM};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[pi] = word;
        pi++;
    endtask

    task automatic new_program();
        for (int i = 0; i < 128; i++)
            imem[i] = EBREAK;
        pi = 0;
    endtask

    // Bit 11 kept clear so LUI plus ADDI gives the sign-extended value
    task automatic load_imm32(input logic [4:0] rd, input logic [31:0] v);
        emit(enc_u(v[31:12], rd, OPC_LUI));
        emit(enc_i(v[11:0], rd, 3'b000, rd, OPC_OP_IMM));
    endtask

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic run_program(input string name);
        int cycles;
        @(posedge clk);
        #1 rst = 1'b0;
        repeat (2) @(posedge clk);
        dmem.delete();
        st_data.delete();
        st_op.delete();
        ld_op.delete();
        trace.delete();
        #1 rst = 1'b1;
        cycles = 0;
        while (!(done || error) && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (!(done || error)) begin
            $display("%s: core did not halt within 200 cycles", name);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int e0);
        tests++;
        $display("%s: %0d errors", name, errors - e0);
    endtask

    task automatic test_arith();
        logic [31:0] va;
        logic [31:0] vb;
        logic [5:0]  ka;
        logic [5:0]  kb;
        logic [5:0]  sh;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] exp [8];
        int          e0;
        e0 = errors;
        for (int r = 0; r < 2; r++) begin
            va = lcg_next() & ~32'h800;
            vb = lcg_next() & ~32'h800;
            ka = 6'(lcg_next() & 32'h1f);
            kb = 6'(lcg_next() & 32'h1f);
            sh = 6'(lcg_next() & 32'h3f);
            a = {{32{va[31]}}, va} << ka;
            b = {{32{vb[31]}}, vb} << kb;
            exp = '{a + b, a - b, a & b, a | b, a ^ b,
                    {63'b0, $signed(a) < $signed(b)}, {63'b0, $signed(b) < $signed(a)},
                    a >> sh};
            new_program();
            load_imm32(5'd1, va);
            emit(enc_i({6'b0, ka}, 5'd1, 3'b001, 5'd1, OPC_OP_IMM));
            load_imm32(5'd2, vb);
            emit(enc_i({6'b0, kb}, 5'd2, 3'b001, 5'd2, OPC_OP_IMM));
            emit(enc_u(20'h1, 5'd3, OPC_LUI));
            emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));
            emit(enc_s(12'd0, 5'd4, 5'd3, 3'b011));
            emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
            emit(enc_s(12'd8, 5'd4, 5'd3, 3'b011));
            emit(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd4));
            emit(enc_s(12'd16, 5'd4, 5'd3, 3'b011));
            emit(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd4));
            emit(enc_s(12'd24, 5'd4, 5'd3, 3'b011));
            emit(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd4));
            emit(enc_s(12'd32, 5'd4, 5'd3, 3'b011));
            emit(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd4));
            emit(enc_s(12'd40, 5'd4, 5'd3, 3'b011));
            emit(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd4));
            emit(enc_s(12'd48, 5'd4, 5'd3, 3'b011));
            emit(enc_i({6'b0, sh}, 5'd1, 3'b101, 5'd4, OPC_OP_IMM));
            emit(enc_s(12'd56, 5'd4, 5'd3, 3'b011));
            run_program("arith");
            check("arith store count", 8, st_data.size());
            for (int i = 0; i < 8 && i < st_data.size(); i++)
                check("arith", exp[i], st_data[i]);
        end
        finish_test("arith", e0);
    endtask

    task automatic test_load_store();
        logic [31:0] va;
        logic [31:0] vb;
        logic [63:0] v;
        logic [63:0] exp [14];
        logic [2:0]  s_ops [14];
        logic [2:0]  l_ops [10];
        int          e0;
        e0 = errors;
        va = lcg_next() & ~32'h800;
        vb = lcg_next() & ~32'h800;
        v = ({{32{va[31]}}, va} << 24) + {{32{vb[31]}}, vb};
        l_ops = '{3'd0, 3'd4, 3'd1, 3'd5, 3'd2, 3'd6, 3'd3, 3'd2, 3'd1, 3'd0};
        s_ops = '{3'd3, 3'd2, 3'd1, 3'd0, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3,
                  3'd3, 3'd3, 3'd3};
        exp = '{v, v, v, v,
                {{56{v[7]}}, v[7:0]}, {56'b0, v[7:0]},
                {{48{v[15]}}, v[15:0]}, {48'b0, v[15:0]},
                {{32{v[31]}}, v[31:0]}, {32'b0, v[31:0]}, v,
                {{32{v[31]}}, v[31:0]}, {{48{v[15]}}, v[15:0]}, {{56{v[7]}}, v[7:0]}};
        new_program();
        load_imm32(5'd1, va);
        emit(enc_i(12'd24, 5'd1, 3'b001, 5'd1, OPC_OP_IMM));
        load_imm32(5'd2, vb);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd1));
        emit(enc_u(20'h1, 5'd3, OPC_LUI));
        for (int i = 0; i < 4; i++)
            emit(enc_s(12'(8 * i), 5'd1, 5'd3, s_ops[i]));
        for (int i = 0; i < 10; i++) begin
            emit(enc_i(12'(i < 7 ? 0 : 8 * (i - 6)), 5'd3, l_ops[i], 5'd4, OPC_LOAD));
            emit(enc_s(12'(32 + 8 * i), 5'd4, 5'd3, 3'b011));
        end
        run_program("load_store");
        check("load_store store count", 14, st_data.size());
        check("load_store load count", 10, ld_op.size());
        for (int i = 0; i < 14 && i < st_data.size(); i++) begin
            check("load_store data", exp[i], st_data[i]);
            check("load_store store op", s_ops[i], st_op[i]);
        end
        for (int i = 0; i < 10 && i < ld_op.size(); i++)
            check("load_store load op", l_ops[i], ld_op[i]);
        finish_test("load_store", e0);
    endtask

    task automatic test_control();
        int exp_idx [16];
        int e0;
        e0 = errors;
        exp_idx = '{0, 1, 2, 3, 5, 7, 8, 9, 11, 13, 16, 17, 19, 20, 21, 22};
        new_program();
        emit(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        emit(enc_i(-12'sd3, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'b000));
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'b001));
        emit(EBREAK);
        emit(enc_b(13'd8, 5'd1, 5'd2, 3'b100));
        emit(EBREAK);
        emit(enc_b(13'd8, 5'd1, 5'd2, 3'b101));
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'b100));
        emit(enc_b(13'd8, 5'd1, 5'd1, 3'b000));
        emit(EBREAK);
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'b101));
        emit(EBREAK);
        emit(enc_j(21'd12, 5'd5));
        emit(EBREAK);
        emit(EBREAK);
        emit(enc_u(20'h0, 5'd7, OPC_AUIPC));
        // JALR clears bit 0 of the odd target
        emit(enc_i(12'd13, 5'd7, 3'b000, 5'd6, OPC_JALR));
        emit(EBREAK);
        emit(enc_u(20'h1, 5'd3, OPC_LUI));
        emit(enc_b(13'd8, 5'd1, 5'd1, 3'b001));
        emit(enc_s(12'd0, 5'd5, 5'd3, 3'b011));
        emit(enc_s(12'd8, 5'd6, 5'd3, 3'b011));
        run_program("control");
        check("control trace length", 16, trace.size());
        for (int i = 0; i < 16 && i < trace.size(); i++)
            check("control pc", RESET_PC + 4 * exp_idx[i], trace[i]);
        check("control store count", 2, st_data.size());
        if (st_data.size() == 2) begin
            check("control jal link", RESET_PC + 56, st_data[0]);
            check("control jalr link", RESET_PC + 72, st_data[1]);
        end
        finish_test("control", e0);
    endtask

    task automatic test_csr_trap();
        logic [63:0] exp [9];
        int          e0;
        int          ecall_seen;
        e0 = errors;
        ecall_seen = 0;
        exp = '{64'h0, 64'h1a5, 64'h1af, 64'h00a, 64'h00a, 64'h008,
                64'd11, RESET_PC + 72, 64'd77};
        new_program();
        emit(enc_u(20'h1, 5'd3, OPC_LUI));
        emit(enc_i(12'h1a5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        emit(enc_i(12'h00a, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
        emit(enc_csr(CSR_MSTATUS, 5'd1, 3'b001, 5'd4));
        emit(enc_csr(CSR_MSTATUS, 5'd2, 3'b010, 5'd5));
        emit(enc_csr(CSR_MSTATUS, 5'd1, 3'b011, 5'd6));
        emit(enc_csr(CSR_MSTATUS, 5'd0, 3'b110, 5'd7));
        emit(enc_csr(CSR_MSTATUS, 5'd2, 3'b111, 5'd8));
        emit(enc_csr(CSR_MSTATUS, 5'd0, 3'b010, 5'd9));
        for (int i = 0; i < 6; i++)
            emit(enc_s(12'(8 * i), 5'(4 + i), 5'd3, 3'b011));
        emit(enc_u(20'h0, 5'd10, OPC_AUIPC));
        emit(enc_i(12'd196, 5'd10, 3'b000, 5'd10, OPC_OP_IMM));
        emit(enc_csr(CSR_MTVEC, 5'd10, 3'b001, 5'd0));
        emit(ECALL);
        emit(enc_i(12'd77, 5'd0, 3'b000, 5'd14, OPC_OP_IMM));
        emit(enc_s(12'd64, 5'd14, 5'd3, 3'b011));
        emit(EBREAK);
        // Trap handler at offset 256
        pi = 64;
        emit(enc_csr(CSR_MCAUSE, 5'd0, 3'b010, 5'd11));
        emit(enc_csr(CSR_MEPC, 5'd0, 3'b010, 5'd12));
        emit(enc_i(12'd4, 5'd12, 3'b000, 5'd13, OPC_OP_IMM));
        emit(enc_csr(CSR_MEPC, 5'd13, 3'b001, 5'd0));
        emit(enc_s(12'd48, 5'd11, 5'd3, 3'b011));
        emit(enc_s(12'd56, 5'd12, 5'd3, 3'b011));
        emit(MRET);
        run_program("csr_trap");
        check("csr_trap store count", 9, st_data.size());
        for (int i = 0; i < 9 && i < st_data.size(); i++)
            check("csr_trap", exp[i], st_data[i]);
        for (int i = 0; i + 1 < trace.size(); i++) begin
            if (trace[i] == RESET_PC + 72 && ecall_seen == 0) begin
                check("csr_trap ecall target", RESET_PC + 256, trace[i + 1]);
                ecall_seen = 1;
            end
        end
        if (ecall_seen == 0) begin
            $display("csr_trap: ECALL address never reached");
            errors++;
        end
        finish_test("csr_trap", e0);
    endtask

    task automatic test_halt(input string name, input logic [31:0] word, input bit is_error);
        int e0;
        e0 = errors;
        new_program();
        emit(enc_u(20'h1, 5'd3, OPC_LUI));
        emit(enc_i(12'd9, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        emit(enc_s(12'd0, 5'd1, 5'd3, 3'b011));
        emit(word);
        emit(enc_s(12'd8, 5'd1, 5'd3, 3'b011));
        run_program(name);
        for (int i = 0; i < 4; i++) begin
            check({name, " error"}, is_error, error);
            check({name, " done"}, !is_error, done);
            check({name, " pc"}, RESET_PC + 12, pc);
            @(negedge clk);
        end
        check({name, " store count"}, 1, st_data.size());
        finish_test(name, e0);
    endtask

    initial begin
        rst = 1'b0;
        seed = 32'h2aa5_de4b;
        errors = 0;
        tests = 0;
        new_program();
        test_arith();
        test_load_store();
        test_control();
        test_csr_trap();
        test_halt("illegal_zero", 32'h0, 1'b1);
        test_halt("illegal_csr", enc_csr(12'h7c0, 5'd1, 3'b001, 5'd4), 1'b1);
        test_halt("ebreak_done", EBREAK, 1'b0);
        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== rtl/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [31:0]               instr,
    input  logic [cpu_pkg::XLEN-1:0]  data_rd,
    output logic [cpu_pkg::XLEN-1:0]  pc,
    output cpu_pkg::mem_req_t         mem,
    output logic                      error,
    output logic                      done
);
    import cpu_pkg::*;

    ctrl_t           ctrl;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    logic [11:0]     csr_addr;
    logic            illegal;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic            take_branch;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] csr_rdata;
    logic            trap_taken;
    logic [XLEN-1:0] trap_pc;
    logic            commit;

    pc_unit i_pc_unit (
        .clk(clk), .rst(rst), .commit(commit),
        .take_branch(take_branch), .target(target),
        .trap_taken(trap_taken), .trap_pc(trap_pc),
        .pc(pc)
    );

    instr_decode i_instr_decode (
        .instr(instr), .ctrl(ctrl),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .csr_addr(csr_addr), .illegal(illegal)
    );

    // Writes only retire when the core is not halted
    reg_file i_reg_file (
        .clk(clk), .rst(rst),
        .wen(ctrl.reg_wr && commit), .waddr(rd), .wdata(wb_data),
        .raddr1(rs1), .raddr2(rs2),
        .rdata1(src1), .rdata2(src2)
    );

    exec_unit i_exec_unit (
        .ctrl(ctrl), .commit(commit),
        .src1(src1), .src2(src2), .imm(imm), .pc(pc),
        .data_rd(data_rd), .csr_rdata(csr_rdata),
        .take_branch(take_branch), .target(target),
        .wb_data(wb_data), .mem(mem)
    );

    csr_file i_csr_file (
        .clk(clk), .rst(rst), .ctrl(ctrl), .illegal(illegal),
        .csr_addr(csr_addr), .src1(src1), .zimm(rs1), .pc(pc),
        .csr_rdata(csr_rdata), .trap_taken(trap_taken), .trap_pc(trap_pc),
        .csr_err(), .commit(commit), .error(error), .done(done)
    );

endmodule

// ==== rtl/csr_file.sv ====
`timescale 1ns/1ps

module csr_file (
    input  logic                     clk,
    input  logic                     rst,
    input  cpu_pkg::ctrl_t           ctrl,
    input  logic                     illegal,
    input  logic [11:0]              csr_addr,
    input  logic [cpu_pkg::XLEN-1:0] src1,
    input  logic [4:0]               zimm,
    input  logic [cpu_pkg::XLEN-1:0] pc,
    output logic [cpu_pkg::XLEN-1:0] csr_rdata,
    output logic                     trap_taken,
    output logic [cpu_pkg::XLEN-1:0] trap_pc,
    output logic                     csr_err,
    output logic                     commit,
    output logic                     error,
    output logic                     done
);
    import cpu_pkg::*;

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] operand;
    logic [XLEN-1:0] csr_wdata;
    logic            csr_hit;
    logic            csr_we;

    always_comb begin
        csr_hit = 1'b1;
        case (csr_addr)
            CSR_MSTATUS: csr_rdata = mstatus;
            CSR_MTVEC:   csr_rdata = mtvec;
            CSR_MEPC:    csr_rdata = mepc;
            CSR_MCAUSE:  csr_rdata = mcause;
            default: begin
                csr_rdata = '0;
                csr_hit   = 1'b0;
            end
        endcase
    end

    assign csr_err = ctrl.csr && !csr_hit;
    assign error   = illegal || csr_err;
    assign done    = ctrl.ebreak;
    assign commit  = !(error || done);

    assign operand = ctrl.csr_imm ? {59'b0, zimm} : src1;

    always_comb begin
        case (ctrl.csr_op)
            2'b10:   csr_wdata = csr_rdata | operand;
            2'b11:   csr_wdata = csr_rdata & ~operand;
            default: csr_wdata = operand;
        endcase
    end

    // Set and clear with rs1 = x0 or zimm = 0 leave the CSR untouched
    assign csr_we = ctrl.csr && commit && (ctrl.csr_op == 2'b01 || zimm != 5'd0);

    assign trap_taken = ctrl.ecall || ctrl.mret;
    assign trap_pc    = ctrl.mret ? mepc : mtvec;

    always_ff @(posedge clk) begin
        if (!rst) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (commit && ctrl.ecall) begin
            mepc                  <= pc;
            mcause                <= CAUSE_ECALL_M;
            mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
            mstatus[MSTATUS_MIE]  <= 1'b0;
        end else if (commit && ctrl.mret) begin
            mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
            mstatus[MSTATUS_MPIE] <= 1'b1;
        end else if (csr_we) begin
            case (csr_addr)
                CSR_MSTATUS: mstatus <= csr_wdata;
                // Trap targets stay word aligned
                CSR_MTVEC:   mtvec   <= {csr_wdata[XLEN-1:2], 2'b00};
                CSR_MEPC:    mepc    <= {csr_wdata[XLEN-1:2], 2'b00};
                default:     mcause  <= csr_wdata;
            endcase
        end
    end

endmodule

// ==== rtl/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
    input  cpu_pkg::ctrl_t           ctrl,
    input  logic                     commit,
    input  logic [cpu_pkg::XLEN-1:0] src1,
    input  logic [cpu_pkg::XLEN-1:0] src2,
    input  logic [cpu_pkg::XLEN-1:0] imm,
    input  logic [cpu_pkg::XLEN-1:0] pc,
    input  logic [cpu_pkg::XLEN-1:0] data_rd,
    input  logic [cpu_pkg::XLEN-1:0] csr_rdata,
    output logic                     take_branch,
    output logic [cpu_pkg::XLEN-1:0] target,
    output logic [cpu_pkg::XLEN-1:0] wb_data,
    output cpu_pkg::mem_req_t        mem
);
    import cpu_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] pc_plus4;
    logic            br_cond;

    assign pc_plus4 = pc + 64'd4;

    always_comb begin
        case (ctrl.a_sel)
            A_PC:    op_a = pc;
            A_ZERO:  op_a = '0;
            default: op_a = src1;
        endcase
        case (ctrl.b_sel)
            B_IMM:   op_b = imm;
            default: op_b = src2;
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SLT:    alu_result = {63'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLL:    alu_result = op_a << op_b[5:0];
            ALU_SRL:    alu_result = op_a >> op_b[5:0];
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    // Only BEQ, BNE, BLT and BGE get past decode
    always_comb begin
        case (ctrl.br_op)
            3'b000:  br_cond = (src1 == src2);
            3'b001:  br_cond = (src1 != src2);
            3'b100:  br_cond = ($signed(src1) < $signed(src2));
            default: br_cond = ($signed(src1) >= $signed(src2));
        endcase
    end

    assign take_branch = ctrl.jump || (ctrl.br && br_cond);
    // Branch and JAL targets come out of the ALU as pc + imm
    assign target = ctrl.jalr ? {alu_result[XLEN-1:1], 1'b0} : alu_result;

    assign mem.rd    = ctrl.mem_rd && commit;
    assign mem.wr    = ctrl.mem_wr && commit;
    assign mem.op    = ctrl.mem_op;
    assign mem.addr  = alu_result;
    assign mem.wdata = src2;

    always_comb begin
        if (ctrl.jump)
            wb_data = pc_plus4;
        else if (ctrl.mem_rd)
            wb_data = data_rd;
        else if (ctrl.csr)
            wb_data = csr_rdata;
        else
            wb_data = alu_result;
    end

endmodule

// ==== rtl/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
    input  logic [31:0]              instr,
    output cpu_pkg::ctrl_t           ctrl,
    output logic [4:0]               rs1,
    output logic [4:0]               rs2,
    output logic [4:0]               rd,
    output logic [cpu_pkg::XLEN-1:0] imm,
    output logic [11:0]              csr_addr,
    output logic                     illegal
);
    import cpu_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign rd       = instr[11:7];
    assign csr_addr = instr[31:20];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        ctrl.a_sel  = A_RS1;
        ctrl.b_sel  = B_IMM;
        imm         = imm_i;
        illegal     = 1'b0;
        case (opcode)
            OPC_OP: begin
                ctrl.b_sel  = B_RS2;
                ctrl.reg_wr = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: ctrl.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: ctrl.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: ctrl.alu_op = ALU_XOR;
                    {7'b0000000, 3'b010}: ctrl.alu_op = ALU_SLT;
                    default:              illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                ctrl.reg_wr = 1'b1;
                // RV64 shifts take a 6-bit shamt, so only funct6 is checked
                if (funct3 == 3'b000)
                    ctrl.alu_op = ALU_ADD;
                else if (funct3 == 3'b001 && instr[31:26] == 6'b0)
                    ctrl.alu_op = ALU_SLL;
                else if (funct3 == 3'b101 && instr[31:26] == 6'b0)
                    ctrl.alu_op = ALU_SRL;
                else
                    illegal = 1'b1;
            end
            OPC_LUI: begin
                ctrl.a_sel  = A_ZERO;
                ctrl.alu_op = ALU_PASS_B;
                ctrl.reg_wr = 1'b1;
                imm         = imm_u;
            end
            OPC_AUIPC: begin
                ctrl.a_sel  = A_PC;
                ctrl.reg_wr = 1'b1;
                imm         = imm_u;
            end
            OPC_JAL: begin
                ctrl.a_sel  = A_PC;
                ctrl.reg_wr = 1'b1;
                ctrl.jump   = 1'b1;
                imm         = imm_j;
            end
            OPC_JALR: begin
                ctrl.reg_wr = 1'b1;
                ctrl.jump   = 1'b1;
                ctrl.jalr   = 1'b1;
                illegal     = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                ctrl.a_sel = A_PC;
                ctrl.br    = 1'b1;
                ctrl.br_op = funct3;
                imm        = imm_b;
                illegal    = !(funct3 inside {3'b000, 3'b001, 3'b100, 3'b101});
            end
            OPC_LOAD: begin
                ctrl.reg_wr = 1'b1;
                ctrl.mem_rd = 1'b1;
                ctrl.mem_op = funct3;
                illegal     = (funct3 == 3'b111);
            end
            OPC_STORE: begin
                ctrl.mem_wr = 1'b1;
                ctrl.mem_op = funct3;
                imm         = imm_s;
                illegal     = funct3[2];
            end
            OPC_SYSTEM: begin
                if (funct3 == 3'b000) begin
                    case (instr)
                        32'h0000_0073: ctrl.ecall  = 1'b1;
                        32'h0010_0073: ctrl.ebreak = 1'b1;
                        32'h3020_0073: ctrl.mret   = 1'b1;
                        default:       illegal     = 1'b1;
                    endcase
                end else if (funct3 == 3'b100) begin
                    illegal = 1'b1;
                end else begin
                    ctrl.csr     = 1'b1;
                    ctrl.csr_imm = funct3[2];
                    ctrl.csr_op  = funct3[1:0];
                    ctrl.reg_wr  = (rd != 5'd0);
                end
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

// ==== rtl/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     commit,
    input  logic                     take_branch,
    input  logic [cpu_pkg::XLEN-1:0] target,
    input  logic                     trap_taken,
    input  logic [cpu_pkg::XLEN-1:0] trap_pc,
    output logic [cpu_pkg::XLEN-1:0] pc
);
    import cpu_pkg::*;

    logic [XLEN-1:0] next_pc;

    // Trap beats branch beats sequential
    always_comb begin
        if (trap_taken)
            next_pc = trap_pc;
        else if (take_branch)
            next_pc = target;
        else
            next_pc = pc + 64'd4;
    end

    always_ff @(posedge clk) begin
        if (!rst)
            pc <= RESET_PC;
        else if (commit)
            pc <= next_pc;
    end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wen,
    input  logic [4:0]               waddr,
    input  logic [cpu_pkg::XLEN-1:0] wdata,
    input  logic [4:0]               raddr1,
    input  logic [4:0]               raddr2,
    output logic [cpu_pkg::XLEN-1:0] rdata1,
    output logic [cpu_pkg::XLEN-1:0] rdata2
);
    import cpu_pkg::*;

    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module tb_cpu_core -f compile.f -o tb_cpu_core

./obj_dir/tb_cpu_core > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then
    exit 1
fi
exit 0
